// ==== flist.f ====
+incdir+include
logic/arch_defs_pkg.sv
logic/control_unit.sv
logic/address_unit.sv
logic/cpu_datapath.sv
logic/program_ram.sv
logic/cpu_top.sv
tb/tb_cpu.sv

// ==== logic/address_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module address_unit import arch_defs_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  control_word_t control_word,
    input  logic [7:0]    bus,
    output logic [15:0]   mem_addr,
    output logic [15:0]   pc
);

    // PC and MAR, MAR drives the RAM address directly
    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= 16'h0000;
            mem_addr <= 16'h0000;
        end else begin
            if (control_word.load_origin) begin
                pc <= 16'h0000;
            end else if (control_word.pc_enable) begin
                pc <= pc + 16'd1;
            end else begin
                if (control_word.load_pc_low_byte)
                    pc[7:0] <= bus;               // Jump target low
                if (control_word.load_pc_high_byte)
                    pc[15:8] <= bus;
            end

            if (control_word.load_mar_pc) begin
                mem_addr <= pc;                   // Fetch address
            end else begin
                if (control_word.load_mar_addr_low)
                    mem_addr[7:0] <= bus;         // Operand address
                if (control_word.load_mar_addr_high)
                    mem_addr[15:8] <= bus;
            end
        end
    end

    // Fetch increment and jump load come from different FSM phases
    assert property (@(posedge clk) disable iff (reset)
        !(control_word.pc_enable &&
          (control_word.load_pc_low_byte || control_word.load_pc_high_byte)));

endmodule

`default_nettype wire

// ==== logic/arch_defs_pkg.sv ====
`default_nettype none

package arch_defs_pkg;

    // =========================================================================
    // Instruction set
    // =========================================================================
    typedef enum logic [7:0] {
        NOP   = 8'h00,
        LDI_A = 8'h01,
        LDI_B = 8'h02,
        LDI_C = 8'h03,
        LDA   = 8'h04,
        JMP   = 8'h05,
        JZ    = 8'h06,
        JNZ   = 8'h07,
        JN    = 8'h08,
        HLT   = 8'hFF
    } opcode_t;

    // Sequencer states
    typedef enum logic [2:0] {
        S_RESET,
        S_INIT,
        S_LATCH_ADDR,
        S_READ_BYTE,
        S_LATCH_BYTE,
        S_CHK_MORE_BYTES,
        S_EXECUTE,
        S_HALT
    } fsm_state_t;

    typedef enum logic [2:0] {
        MS0, MS1, MS2, MS3, MS4, MS5, MS6, MS7
    } microstep_t;

    // =========================================================================
    // Control word, one strobe per field
    // =========================================================================
    typedef struct packed {
        logic load_origin;        // Clear PC
        logic load_mar_pc;        // MAR <= PC
        logic load_mar_addr_low;
        logic load_mar_addr_high;
        logic oe_ram;             // RAM data onto bus
        logic pc_enable;          // PC increment
        logic load_ir;
        logic load_temp_1;
        logic load_temp_2;
        logic oe_temp_1;
        logic oe_temp_2;
        logic load_pc_low_byte;
        logic load_pc_high_byte;
        logic load_a;
        logic load_b;
        logic load_c;
        logic load_flags;
        logic load_sets_zn;       // Z and N taken from bus value
        logic halt;
        logic last_step;          // Final microstep of instruction
        logic check_zero;
        logic check_not_zero;
        logic check_carry;
        logic check_negative;
    } control_word_t;

    // Flag bit positions
    localparam int flag_zero     = 0;
    localparam int flag_carry    = 1;
    localparam int flag_negative = 2;

endpackage

`default_nettype wire

// ==== logic/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit import arch_defs_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  opcode_t       opcode,
    input  logic [2:0]    flags,
    output control_word_t control_word,
    output logic          halted
);

    fsm_state_t    state, next_state;
    microstep_t    step, next_step;
    logic [1:0]    byte_count, next_byte_count;
    logic [1:0]    num_operand_bytes;
    logic          opcode_known;
    control_word_t rom_word;
    logic          cond_checked;
    logic          cond_met;

    // =========================================================================
    // Operand count table
    // =========================================================================
    always_comb begin
        opcode_known = 1'b1;
        case (opcode)
            NOP, HLT:                num_operand_bytes = 2'd0;
            LDI_A, LDI_B, LDI_C:     num_operand_bytes = 2'd1;
            LDA, JMP, JZ, JNZ, JN:   num_operand_bytes = 2'd2;
            default: begin
                num_operand_bytes = 2'd0;
                opcode_known = 1'b0;    // Sends FSM to halt
            end
        endcase
    end

    // =========================================================================
    // Microcode ROM
    // =========================================================================
    function automatic control_word_t microcode_row(opcode_t op, microstep_t ms);
        control_word_t cw;
        cw = '0;
        case (op)
            NOP: cw.last_step = 1'b1;
            LDI_A, LDI_B, LDI_C: begin
                cw.oe_temp_1    = 1'b1;
                cw.load_a       = (op == LDI_A);
                cw.load_b       = (op == LDI_B);
                cw.load_c       = (op == LDI_C);
                cw.load_flags   = 1'b1;
                cw.load_sets_zn = 1'b1;
                cw.last_step    = 1'b1;
            end
            JMP, JZ, JNZ, JN: begin
                if (ms == MS0) begin
                    cw.oe_temp_1        = 1'b1;  // Low target byte
                    cw.load_pc_low_byte = 1'b1;
                end else begin
                    cw.oe_temp_2         = 1'b1; // High target byte
                    cw.load_pc_high_byte = 1'b1;
                    cw.last_step         = 1'b1;
                end
                // Check bit on both steps, so a miss leaves PC alone
                cw.check_zero     = (op == JZ);
                cw.check_not_zero = (op == JNZ);
                cw.check_negative = (op == JN);
            end
            LDA: begin
                case (ms)
                    MS0: cw.oe_temp_1 = 1'b1;
                    MS1: begin
                        cw.oe_temp_1         = 1'b1;
                        cw.load_mar_addr_low = 1'b1;
                    end
                    MS2: cw.oe_temp_2 = 1'b1;
                    MS3: begin
                        cw.oe_temp_2          = 1'b1;
                        cw.load_mar_addr_high = 1'b1;
                    end
                    MS4: cw.oe_ram = 1'b1;      // RAM read in flight
                    default: begin
                        cw.oe_ram       = 1'b1;
                        cw.load_a       = 1'b1;
                        cw.load_flags   = 1'b1;
                        cw.load_sets_zn = 1'b1;
                        cw.last_step    = 1'b1;
                    end
                endcase
            end
            default: cw.halt = 1'b1;            // HLT and anything unknown
        endcase
        return cw;
    endfunction

    assign rom_word = microcode_row(opcode, step);

    assign cond_checked = rom_word.check_zero | rom_word.check_not_zero |
                          rom_word.check_negative;
    assign cond_met = (rom_word.check_zero     &  flags[flag_zero])  |
                      (rom_word.check_not_zero & ~flags[flag_zero])  |
                      (rom_word.check_negative &  flags[flag_negative]);

    // =========================================================================
    // Sequencer
    // =========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_RESET;
            step       <= MS0;
            byte_count <= 2'd0;
        end else begin
            state      <= next_state;
            step       <= next_step;
            byte_count <= next_byte_count;
        end
    end

    always_comb begin
        next_state      = state;
        next_step       = step;
        next_byte_count = byte_count;
        control_word    = '0;
        case (state)
            S_RESET: next_state = S_INIT;
            S_INIT: begin
                control_word.load_origin = 1'b1;
                next_state = S_LATCH_ADDR;
            end
            S_LATCH_ADDR: begin
                control_word.load_mar_pc = 1'b1;
                next_state = S_READ_BYTE;
            end
            S_READ_BYTE: begin
                control_word.oe_ram = 1'b1;
                next_state = S_LATCH_BYTE;
            end
            S_LATCH_BYTE: begin
                if (byte_count == 2'd3) begin
                    next_state = S_HALT;            // Byte overflow
                end else begin
                    control_word.oe_ram      = 1'b1;
                    control_word.pc_enable   = 1'b1;
                    control_word.load_ir     = (byte_count == 2'd0);
                    control_word.load_temp_1 = (byte_count == 2'd1);
                    control_word.load_temp_2 = (byte_count == 2'd2);
                    next_byte_count = byte_count + 2'd1;
                    next_state = S_CHK_MORE_BYTES;
                end
            end
            S_CHK_MORE_BYTES: begin
                if (!opcode_known) begin
                    next_state = S_HALT;
                end else if (byte_count > num_operand_bytes) begin
                    next_state      = S_EXECUTE;
                    next_byte_count = 2'd0;
                end else begin
                    next_state = S_LATCH_ADDR;
                end
            end
            S_EXECUTE: begin
                control_word = rom_word;
                if (rom_word.halt) begin
                    next_state = S_HALT;
                    next_step  = MS0;
                end else if (cond_checked && !cond_met) begin
                    control_word.load_pc_low_byte  = 1'b0;  // Branch not taken
                    control_word.load_pc_high_byte = 1'b0;
                    next_state = S_LATCH_ADDR;
                    next_step  = MS0;
                end else if (rom_word.last_step) begin
                    next_state = S_LATCH_ADDR;
                    next_step  = MS0;
                end else begin
                    next_step = microstep_t'(step + 3'd1);
                end
            end
            default: next_state = S_HALT;           // S_HALT holds until reset
        endcase
    end

    assign halted = (state == S_HALT);

    // Bus has a single driver per cycle
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({control_word.oe_ram, control_word.oe_temp_1, control_word.oe_temp_2}));

    assert property (@(posedge clk) disable iff (reset)
        !(control_word.last_step && control_word.halt));

endmodule

`default_nettype wire

// ==== logic/cpu_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath import arch_defs_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  control_word_t control_word,
    input  logic [7:0]    rd_data,
    output logic [7:0]    bus,
    output opcode_t       opcode,
    output logic [7:0]    reg_a,
    output logic [7:0]    reg_b,
    output logic [7:0]    reg_c,
    output logic [2:0]    flags
);

    logic [7:0] temp_1;     // First operand byte
    logic [7:0] temp_2;     // Second operand byte

    // =========================================================================
    // Shared bus
    // =========================================================================
    always_comb begin
        if (control_word.oe_ram)
            bus = rd_data;
        else if (control_word.oe_temp_1)
            bus = temp_1;
        else if (control_word.oe_temp_2)
            bus = temp_2;
        else
            bus = 8'h00;    // Idle bus reads as zero
    end

    // Instruction and operand capture
    always_ff @(posedge clk) begin
        if (control_word.load_ir)
            opcode <= opcode_t'(bus);
        if (control_word.load_temp_1)
            temp_1 <= bus;
        if (control_word.load_temp_2)
            temp_2 <= bus;
    end

    // =========================================================================
    // Registers and flags
    // =========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_a <= 8'h00;
            reg_b <= 8'h00;
            reg_c <= 8'h00;
            flags <= 3'b000;
        end else begin
            if (control_word.load_a)
                reg_a <= bus;
            if (control_word.load_b)
                reg_b <= bus;
            if (control_word.load_c)
                reg_c <= bus;
            if (control_word.load_flags && control_word.load_sets_zn) begin
                flags[flag_zero]     <= (bus == 8'h00);
                flags[flag_negative] <= bus[7];     // Sign bit
            end                                     // Carry held
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top import arch_defs_pkg::*; #(
    parameter int mem_addr_bits = 8
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        prog_we,
    input  logic [15:0] prog_addr,
    input  logic [7:0]  prog_data,
    output logic [7:0]  reg_a,
    output logic [7:0]  reg_b,
    output logic [7:0]  reg_c,
    output logic [2:0]  flags,
    output logic [15:0] pc,
    output logic        halted
);

    control_word_t control_word;
    opcode_t       opcode;
    logic [7:0]    bus;
    logic [7:0]    rd_data;
    logic [15:0]   mem_addr;

    control_unit i_control_unit (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .flags        (flags),
        .control_word (control_word),
        .halted       (halted)
    );

    address_unit i_address_unit (
        .clk          (clk),
        .reset        (reset),
        .control_word (control_word),
        .bus          (bus),
        .mem_addr     (mem_addr),
        .pc           (pc)
    );

    cpu_datapath i_cpu_datapath (
        .clk          (clk),
        .reset        (reset),
        .control_word (control_word),
        .rd_data      (rd_data),
        .bus          (bus),
        .opcode       (opcode),
        .reg_a        (reg_a),
        .reg_b        (reg_b),
        .reg_c        (reg_c),
        .flags        (flags)
    );

    program_ram #(
        .mem_addr_bits (mem_addr_bits)
    ) i_program_ram (
        .clk       (clk),
        .mem_addr  (mem_addr),
        .rd_data   (rd_data),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data)
    );

endmodule

`default_nettype wire

// ==== logic/program_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module program_ram #(
    parameter int mem_addr_bits = 8
) (
    input  logic        clk,
    input  logic [15:0] mem_addr,
    output logic [7:0]  rd_data,
    input  logic        prog_we,
    input  logic [15:0] prog_addr,
    input  logic [7:0]  prog_data
);

    logic [7:0] mem [2**mem_addr_bits];

    // Registered read for the CPU, write port for loading a program
    always_ff @(posedge clk) begin
        if (prog_we)
            mem[prog_addr[mem_addr_bits-1:0]] <= prog_data;
        rd_data <= mem[mem_addr[mem_addr_bits-1:0]];    // Upper bits ignored
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu -f flist.f -o tb_cpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_cpu_sim 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== include/cpu_model.svh ====
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// Instruction-level reference model, expects arch_defs_pkg imported by the includer
localparam int model_step_limit = 4096;     // Guards against looping images

function automatic void cpu_model_run(
    input  logic [7:0]  image [256],
    output logic [7:0]  exp_a,
    output logic [7:0]  exp_b,
    output logic [7:0]  exp_c,
    output logic [2:0]  exp_flags,
    output logic [15:0] exp_pc,
    output logic        exp_halted
);
    logic [7:0]  op;
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic        taken;
    exp_a = 8'h00;
    exp_b = 8'h00;
    exp_c = 8'h00;
    exp_flags  = 3'b000;
    exp_pc     = 16'h0000;
    exp_halted = 1'b0;
    for (int n = 0; n < model_step_limit && !exp_halted; n++) begin
        op = image[exp_pc[7:0]];
        exp_pc = exp_pc + 16'd1;            // Opcode fetch increments PC
        lo = image[exp_pc[7:0]];
        hi = image[exp_pc[7:0] + 8'd1];
        case (op)
            NOP: ;
            LDI_A, LDI_B, LDI_C, LDA: begin
                exp_pc = exp_pc + ((op == LDA) ? 16'd2 : 16'd1);
                if (op == LDA)
                    lo = image[lo];         // RAM sees only the low byte
                if (op == LDI_B)
                    exp_b = lo;
                else if (op == LDI_C)
                    exp_c = lo;
                else
                    exp_a = lo;
                exp_flags[flag_zero]     = (lo == 8'h00);
                exp_flags[flag_negative] = lo[7];
            end
            JMP, JZ, JNZ, JN: begin
                exp_pc = exp_pc + 16'd2;
                case (op)
                    JZ:      taken = exp_flags[flag_zero];
                    JNZ:     taken = !exp_flags[flag_zero];
                    JN:      taken = exp_flags[flag_negative];
                    default: taken = 1'b1;
                endcase
                if (taken)
                    exp_pc = {hi, lo};
            end
            default: exp_halted = 1'b1;     // HLT and unknown opcodes
        endcase
    end
endfunction

`endif

// ==== tb/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import arch_defs_pkg::*; ();

    localparam int num_programs = 56;               // 6 directed plus 50 random
    localparam logic [31:0] lfsr_seed = 32'h0509_a166;

    logic        clk;
    logic        reset;
    logic        prog_we;
    logic [15:0] prog_addr;
    logic [7:0]  prog_data;
    logic [7:0]  reg_a;
    logic [7:0]  reg_b;
    logic [7:0]  reg_c;
    logic [2:0]  flags;
    logic [15:0] pc;
    logic        halted;

    logic [7:0]  image [256];                       // Program image for the next run
    logic [7:0]  wr_pos;
    logic [31:0] lfsr_state;

    `include "cpu_model.svh"

    cpu_top #(
        .mem_addr_bits (8)
    ) i_cpu_top (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .reg_a     (reg_a),
        .reg_b     (reg_b),
        .reg_c     (reg_c),
        .flags     (flags),
        .pc        (pc),
        .halted    (halted)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // =========================================================================
    // Random bits and image building
    // =========================================================================
    function automatic logic [7:0] take_bits(int n);
        logic [7:0] v;
        v = 8'h00;
        for (int k = 0; k < n; k++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic fill_image();
        for (int i = 0; i < 256; i++)
            image[i[7:0]] = i[7:0] ^ 8'h5A;         // Address-dependent background
        wr_pos = 8'h00;
    endtask

    task automatic put_byte(logic [7:0] b);
        image[wr_pos] = b;
        wr_pos = wr_pos + 8'd1;
    endtask

    // First byte of the list sits in the most significant position
    task automatic put_code(logic [7:0] at, int n, logic [319:0] bytes);
        logic [319:0] shifted;
        for (int k = 0; k < n; k++) begin
            shifted = bytes >> (8 * (n - 1 - k));
            image[at + k[7:0]] = shifted[7:0];
        end
    endtask

    task automatic build_random();
        logic [7:0] kind;
        fill_image();
        for (int n = 0; n < 24; n++) begin          // At most 120 code bytes
            kind = take_bits(3);
            case (kind)
                8'd0, 8'd1, 8'd2: begin
                    put_byte(8'h01 + kind);         // LDI_A, LDI_B or LDI_C
                    put_byte(take_bits(8));
                end
                8'd3: begin
                    put_byte(LDA);
                    put_byte(8'h80 | take_bits(7)); // Data in the high half
                    put_byte(8'h00);
                end
                8'd4: put_byte(NOP);
                default: begin
                    put_byte(8'h05 + take_bits(2)); // JMP, JZ, JNZ or JN
                    put_byte(wr_pos + 8'd4);        // Lands past one LDI_C
                    put_byte(8'h00);
                    put_byte(LDI_C);
                    put_byte(take_bits(8));
                end
            endcase
        end
        put_byte(HLT);
    endtask

    // =========================================================================
    // Checks
    // =========================================================================
    task automatic check_value(string what, logic [15:0] expected, logic [15:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", what, expected, actual);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_final(string name, logic [7:0] a, logic [7:0] b, logic [7:0] c,
                               logic [2:0] f, logic [15:0] p);
        check_value({name, " reg_a"}, 16'(a), 16'(reg_a));
        check_value({name, " reg_b"}, 16'(b), 16'(reg_b));
        check_value({name, " reg_c"}, 16'(c), 16'(reg_c));
        check_value({name, " flags"}, 16'(f), 16'(flags));
        check_value({name, " pc"}, p, pc);
    endtask

    // Load the image under reset, run to halt and compare with the model
    task automatic run_program(string name);
        logic [7:0]  exp_a;
        logic [7:0]  exp_b;
        logic [7:0]  exp_c;
        logic [2:0]  exp_flags;
        logic [15:0] exp_pc;
        logic        exp_halted;
        cpu_model_run(image, exp_a, exp_b, exp_c, exp_flags, exp_pc, exp_halted);
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < 256; i++) begin
            prog_we   = 1'b1;
            prog_addr = 16'(i);
            prog_data = image[i[7:0]];
            @(negedge clk);
        end
        prog_we = 1'b0;
        check_final({name, " in reset"}, 8'h00, 8'h00, 8'h00, 3'b000, 16'h0000);
        check_value({name, " halted in reset"}, 16'd0, 16'(halted));
        reset = 1'b0;
        @(negedge clk);
        check_final({name, " after reset"}, 8'h00, 8'h00, 8'h00, 3'b000, 16'h0000);
        check_value({name, " halted after reset"}, 16'd0, 16'(halted));
        while (halted !== 1'b1)
            @(negedge clk);                         // Watchdog bounds this wait
        check_final(name, exp_a, exp_b, exp_c, exp_flags, exp_pc);
        repeat (20) @(negedge clk);
        check_final({name, " held"}, exp_a, exp_b, exp_c, exp_flags, exp_pc);
        check_value({name, " still halted"}, 16'(exp_halted), 16'(halted));
    endtask

    // =========================================================================
    // Watchdog and test sequence
    // =========================================================================
    initial begin
        #(num_programs * (256 * 4 + 256) * 10);
        $display("CPU never halted before the watchdog time ran out");
        $display("test failed");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        reset      = 1'b1;
        prog_we    = 1'b0;
        prog_addr  = 16'h0000;
        prog_data  = 8'h00;
        lfsr_state = lfsr_seed;

        fill_image();
        put_code(8'd0, 7, 320'h01_00_02_7F_03_80_FF);
        run_program("ldi");
        check_final("ldi literal", 8'h00, 8'h7F, 8'h80, 3'b100, 16'h0007);

        fill_image();
        put_code(8'd0, 7, 320'h02_7F_03_80_01_00_FF);   // Zero loaded last
        run_program("ldi_zero");
        check_final("ldi_zero literal", 8'h00, 8'h7F, 8'h80, 3'b001, 16'h0007);

        fill_image();
        put_code(8'hC3, 1, 320'h80);
        put_code(8'd0, 4, 320'h04_C3_00_FF);
        run_program("lda_negative");
        check_final("lda_negative literal", 8'h80, 8'h00, 8'h00, 3'b100, 16'h0004);

        fill_image();
        put_code(8'hE0, 1, 320'h00);
        put_code(8'd0, 4, 320'h04_E0_00_FF);
        run_program("lda_zero");
        check_final("lda_zero literal", 8'h00, 8'h00, 8'h00, 3'b001, 16'h0004);

        // Taken and not-taken branches where skipped LDIs mark the wrong path
        fill_image();
        put_code(8'd0, 10, 320'h01_00_06_07_00_02_EE_07_80_00);
        put_code(8'd10, 10, 320'h01_80_08_11_00_03_EE_06_80_00);
        put_code(8'd20, 10, 320'h07_19_00_02_DD_01_01_08_80_00);
        put_code(8'd30, 8, 320'h05_23_00_03_CC_02_11_FF);
        put_code(8'h80, 3, 320'h03_BB_FF);               // Reached only on a bad branch
        run_program("branches");
        check_final("branches literal", 8'h01, 8'h11, 8'h00, 3'b000, 16'h0026);

        fill_image();
        put_code(8'd0, 6, 320'h01_42_3C_02_99_FF);      // 3C is no opcode
        run_program("unknown_opcode");
        check_final("unknown_opcode literal", 8'h42, 8'h00, 8'h00, 3'b000, 16'h0003);

        for (int n = 0; n < 50; n++) begin
            build_random();
            run_program($sformatf("random_%0d", n));
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
